/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_ptw
FILELIST    ?= project.f
BUILD_DIR   ?= obj_dir
EXTRA_FLAGS ?=

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the build directory $(BUILD_DIR)"
	@echo "make help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR EXTRA_FLAGS"

test:
	$(VERILATOR) --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST) $(EXTRA_FLAGS)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(BUILD_DIR)

/* design/page_table_walker.sv */
`timescale 1ns/1ps

module page_table_walker
  import ptw_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  walk_req_t            i_req,
  input  logic [NUM_PORTS-1:0] i_grant,
  output logic                 o_idle,
  input  ppn_t                 i_satp_ppn,
  output walk_resp_t           o_resp [NUM_PORTS],
  output logic                 o_lookup_valid,
  output paddr_t               o_lookup_addr,
  input  logic                 i_hit,
  input  pte_t                 i_cache_pte,
  output logic                 o_fill_valid,
  output paddr_t               o_fill_addr,
  output pte_t                 o_fill_pte,
  output mem_req_t             o_mem_req,
  input  logic                 i_mem_ready,
  input  logic                 i_mem_resp_valid,
  input  pte_t                 i_mem_resp_data
);

  walk_state_t          r_state;
  walk_state_t          w_next_state;
  logic [NUM_PORTS-1:0] r_grant;
  vpn_t                 r_vpn;
  level_t               r_level;
  paddr_t               r_addr;

  pte_t   w_pte;
  logic   w_start;
  logic   w_is_leaf;
  logic   w_bad_pte;
  logic   w_last_level;
  logic   w_fin;
  logic   w_pte_valid;
  logic   w_done;
  logic   w_step;
  level_t w_next_level;
  paddr_t w_first_addr;
  paddr_t w_next_addr;

  // table base plus the vpn field of the given level scaled to a PTE
  function automatic paddr_t pte_addr(ppn_t base, vpn_t vpn, level_t lvl);
    logic [VPN_FIELD_W-1:0] idx;
    idx = vpn[lvl*VPN_FIELD_W +: VPN_FIELD_W];
    return {base, {PG_IDX_W{1'b0}}} + paddr_t'({idx, {PTE_OFF_W{1'b0}}});
  endfunction

  assign w_start = (r_state == IDLE) & i_req.valid;

  assign w_pte = (r_state == MEM_WAIT) ? i_mem_resp_data : i_cache_pte;

  assign w_is_leaf    = w_pte.v & (w_pte.r | w_pte.w | w_pte.x);
  assign w_bad_pte    = ~w_pte.v | (w_pte.w & ~w_pte.r);
  assign w_last_level = (r_level == '0);
  assign w_fin        = w_is_leaf | w_bad_pte | w_last_level;

  assign w_pte_valid = ((r_state == CACHE_RESULT) & i_hit) |
                       ((r_state == MEM_WAIT) & i_mem_resp_valid);
  assign w_done      = w_pte_valid & w_fin;
  assign w_step      = w_pte_valid & ~w_fin; // descend one level

  assign w_next_level = r_level - 1'b1;
  assign w_first_addr = pte_addr(i_satp_ppn, i_req.vpn, level_t'(PG_LEVELS - 1));
  assign w_next_addr  = pte_addr(w_pte.ppn, r_vpn, w_next_level);

  always_comb begin
    w_next_state = r_state;
    case (r_state)
      IDLE:         if (i_req.valid) w_next_state = CHECK_CACHE;
      CHECK_CACHE:  w_next_state = CACHE_RESULT;
      CACHE_RESULT: begin
        if (!i_hit) w_next_state = MEM_REQUEST;
        else        w_next_state = w_fin ? IDLE : CHECK_CACHE;
      end
      MEM_REQUEST:  if (i_mem_ready) w_next_state = MEM_WAIT;
      MEM_WAIT:     if (i_mem_resp_valid) w_next_state = w_fin ? IDLE : CHECK_CACHE;
      default:      w_next_state = IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
      r_grant <= '0;
      r_level <= '0;
    end else begin
      r_state <= w_next_state;
      if (w_start) begin
        r_grant <= i_grant;
        r_level <= level_t'(PG_LEVELS - 1); // walk starts at the root
      end else if (w_step) begin
        r_level <= w_next_level;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_start) begin
      r_vpn  <= i_req.vpn;
      r_addr <= w_first_addr;
    end else if (w_step) begin
      r_addr <= w_next_addr;
    end
  end

  // result pulse only toward the port held since acceptance
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_resp
    assign o_resp[p] = '{valid: w_done & r_grant[p], pte: w_pte,
                         level: r_level, fault: w_bad_pte};
  end

  assign o_idle = (r_state == IDLE);

  assign o_lookup_valid = (r_state == CHECK_CACHE);
  assign o_lookup_addr  = r_addr;

  assign o_fill_valid = (r_state == MEM_WAIT) & i_mem_resp_valid;
  assign o_fill_addr  = r_addr;
  assign o_fill_pte   = i_mem_resp_data;

  assign o_mem_req = '{valid: (r_state == MEM_REQUEST), addr: r_addr};

endmodule

/* design/pte_cache.sv */
`timescale 1ns/1ps

module pte_cache
  import ptw_pkg::*;
#(
  parameter int CACHE_ENTRIES = 8
) (
  input  logic   i_clk,
  input  logic   i_reset_n,
  input  logic   i_lookup_valid,
  input  paddr_t i_lookup_addr,
  output logic   o_hit,
  output pte_t   o_pte,
  input  logic   i_fill_valid,
  input  paddr_t i_fill_addr,
  input  pte_t   i_fill_pte,
  input  logic   i_flush
);

  localparam int IDX_W = $clog2(CACHE_ENTRIES);
  localparam int TAG_W = PADDR_W - IDX_W - PTE_OFF_W;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  logic [CACHE_ENTRIES-1:0] r_valid;
  tag_t                     r_tag  [CACHE_ENTRIES];
  pte_t                     r_data [CACHE_ENTRIES];

  idx_t w_lookup_idx;
  tag_t w_lookup_tag;
  idx_t w_fill_idx;
  tag_t w_fill_tag;
  logic r_hit;
  pte_t r_pte;

  assign w_lookup_idx = i_lookup_addr[PTE_OFF_W +: IDX_W]; // word index
  assign w_lookup_tag = i_lookup_addr[PADDR_W-1 -: TAG_W];
  assign w_fill_idx   = i_fill_addr[PTE_OFF_W +: IDX_W];
  assign w_fill_tag   = i_fill_addr[PADDR_W-1 -: TAG_W];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_flush) begin
      r_valid <= '0; // sfence beats a fill
    end else if (i_fill_valid) begin
      r_valid[w_fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_valid) begin
      r_tag[w_fill_idx]  <= w_fill_tag;
      r_data[w_fill_idx] <= i_fill_pte;
    end
  end

  // one-cycle registered lookup
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_hit <= 1'b0;
    end else begin
      r_hit <= i_lookup_valid & ~i_flush & r_valid[w_lookup_idx] &
               (r_tag[w_lookup_idx] == w_lookup_tag);
    end
  end

  always_ff @(posedge i_clk) begin
    r_pte <= r_data[w_lookup_idx];
  end

  assign o_hit = r_hit;
  assign o_pte = r_pte;

endmodule

/* design/ptw_pkg.sv */
package ptw_pkg;

  localparam int PTE_W       = 32;
  localparam int PADDR_W     = 34;
  localparam int PPN_W       = 22;
  localparam int VPN_FIELD_W = 10;
  localparam int VPN_W       = 20;
  localparam int PG_IDX_W    = 12;
  localparam int PG_LEVELS   = 2;

  // byte offset bits of one PTE inside a table
  localparam int PTE_OFF_W = $clog2(PTE_W / 8);

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [PPN_W-1:0]   ppn_t;
  typedef logic [VPN_W-1:0]   vpn_t;
  typedef logic [$clog2(PG_LEVELS)-1:0] level_t;

  // Sv32 entry layout with v in bit 0
  typedef struct packed {
    ppn_t       ppn;
    logic [1:0] rsw;
    logic       d;
    logic       a;
    logic       g;
    logic       u;
    logic       x;
    logic       w;
    logic       r;
    logic       v;
  } pte_t;

  typedef struct packed {
    logic valid;
    vpn_t vpn;
  } walk_req_t;

  typedef struct packed {
    logic   valid;
    pte_t   pte;
    level_t level;
    logic   fault;
  } walk_resp_t;

  typedef struct packed {
    logic   valid;
    paddr_t addr;
  } mem_req_t;

  typedef enum logic [2:0] {
    IDLE,
    CHECK_CACHE,
    CACHE_RESULT,
    MEM_REQUEST,
    MEM_WAIT
  } walk_state_t;

endpackage

/* design/ptw_req_arbiter.sv */
`timescale 1ns/1ps

module ptw_req_arbiter
  import ptw_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  input  walk_req_t            i_req [NUM_PORTS],
  input  logic                 i_idle,
  output logic [NUM_PORTS-1:0] o_grant,
  output walk_req_t            o_req
);

  logic [NUM_PORTS-1:0] w_valid;
  logic [NUM_PORTS-1:0] w_oh;

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      w_valid[p] = i_req[p].valid;
    end
  end

  // lowest set bit wins
  assign w_oh = w_valid & ~(w_valid - NUM_PORTS'(1));

  // ready only while the walker sits in IDLE
  assign o_grant = w_oh & {NUM_PORTS{i_idle}};

  // and-or mux over the one-hot
  always_comb begin
    o_req = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      o_req = walk_req_t'(o_req | (i_req[p] & {$bits(walk_req_t){o_grant[p]}}));
    end
  end

endmodule

/* design/ptw_subsystem.sv */
`timescale 1ns/1ps

module ptw_subsystem
  import ptw_pkg::*;
#(
  parameter int NUM_PORTS     = 2,
  parameter int CACHE_ENTRIES = 8
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  ppn_t                 i_satp_ppn,
  input  logic                 i_flush,
  input  walk_req_t            i_req [NUM_PORTS],
  output logic [NUM_PORTS-1:0] o_req_ready,
  output walk_resp_t           o_resp [NUM_PORTS],
  output mem_req_t             o_mem_req,
  input  logic                 i_mem_ready,
  input  logic                 i_mem_resp_valid,
  input  pte_t                 i_mem_resp_data
);

  walk_req_t w_req;
  logic      w_idle;
  logic      w_lookup_valid;
  paddr_t    w_lookup_addr;
  logic      w_hit;
  pte_t      w_cache_pte;
  logic      w_fill_valid;
  paddr_t    w_fill_addr;
  pte_t      w_fill_pte;

  ptw_req_arbiter #(.NUM_PORTS(NUM_PORTS)) u_arbiter (
    .i_req   (i_req),
    .i_idle  (w_idle),
    .o_grant (o_req_ready), // grant doubles as ready
    .o_req   (w_req)
  );

  page_table_walker #(.NUM_PORTS(NUM_PORTS)) u_walker (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_req            (w_req),
    .i_grant          (o_req_ready),
    .o_idle           (w_idle),
    .i_satp_ppn       (i_satp_ppn),
    .o_resp           (o_resp),
    .o_lookup_valid   (w_lookup_valid),
    .o_lookup_addr    (w_lookup_addr),
    .i_hit            (w_hit),
    .i_cache_pte      (w_cache_pte),
    .o_fill_valid     (w_fill_valid),
    .o_fill_addr      (w_fill_addr),
    .o_fill_pte       (w_fill_pte),
    .o_mem_req        (o_mem_req),
    .i_mem_ready      (i_mem_ready),
    .i_mem_resp_valid (i_mem_resp_valid),
    .i_mem_resp_data  (i_mem_resp_data)
  );

  pte_cache #(.CACHE_ENTRIES(CACHE_ENTRIES)) u_cache (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_lookup_valid (w_lookup_valid),
    .i_lookup_addr  (w_lookup_addr),
    .o_hit          (w_hit),
    .o_pte          (w_cache_pte),
    .i_fill_valid   (w_fill_valid),
    .i_fill_addr    (w_fill_addr),
    .i_fill_pte     (w_fill_pte),
    .i_flush        (i_flush)
  );

endmodule

/* project.f */
design/ptw_pkg.sv
design/ptw_req_arbiter.sv
design/pte_cache.sv
design/page_table_walker.sv
design/ptw_subsystem.sv
verification/tb_clock_gen.sv
verification/tb_ptw_asserts.sv
verification/tb_ptw.sv

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic o_clk
);

  initial o_clk = 1'b0;

  always #(PERIOD_NS / 2.0) o_clk = ~o_clk; // free-running

endmodule

/* verification/tb_ptw.sv */
`timescale 1ns/1ps

module tb_ptw
  import ptw_pkg::*;
();

  localparam int   NUM_PORTS      = 2;
  localparam int   TIMEOUT_CYCLES = 200;
  localparam ppn_t SATP_PPN       = 22'h00040;
  localparam int   TABLE_BASE     = 'h200;
  localparam int   LEAF_BASE      = 'h8000;

  logic                 clk;
  logic                 reset_n         = 1'b0;
  logic                 flush           = 1'b0;
  walk_req_t            req [NUM_PORTS] = '{default: '0};
  logic [NUM_PORTS-1:0] req_ready;
  walk_resp_t           resp [NUM_PORTS];
  mem_req_t             mem_req;
  logic                 mem_ready       = 1'b0;
  logic                 mem_resp_valid  = 1'b0;
  pte_t                 mem_resp_data   = '0;
  logic                 mem_busy        = 1'b0;
  paddr_t               mem_addr        = '0;
  int                   mem_delay       = 0;
  int                   mem_req_count   = 0;
  pte_t                 page_table [paddr_t];
  logic                 run_done        = 1'b0;
  logic                 fail_shown      = 1'b0;

  tb_clock_gen #(.PERIOD_NS(8.0)) u_clock (.o_clk(clk));

  ptw_subsystem #(.NUM_PORTS(NUM_PORTS), .CACHE_ENTRIES(8)) i_dut (
    .i_clk            (clk),
    .i_reset_n        (reset_n),
    .i_satp_ppn       (SATP_PPN),
    .i_flush          (flush),
    .i_req            (req),
    .o_req_ready      (req_ready),
    .o_resp           (resp),
    .o_mem_req        (mem_req),
    .i_mem_ready      (mem_ready),
    .i_mem_resp_valid (mem_resp_valid),
    .i_mem_resp_data  (mem_resp_data)
  );

  function automatic pte_t read_pte(paddr_t addr);
    if (page_table.exists(addr)) return page_table[addr];
    return '0; // unmapped reads as invalid
  endfunction

  function automatic logic leaf_pte(pte_t pte);
    return pte.v && (pte.r || pte.w || pte.x);
  endfunction

  function automatic logic faulting_pte(pte_t pte);
    return !pte.v || (pte.w && !pte.r);
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    fail_shown = 1'b1;
    $display("Regression failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    assert (expected == actual) else
      abort_run($sformatf("[ERROR] %s: %s expected 0x%0h, actual 0x%0h",
                          name, field, expected, actual));
  endtask

  // root entries cycle through superpage, pointer, invalid, w without r
  task automatic build_page_table();
    pte_t   pte;
    paddr_t root;
    paddr_t l0_base;
    root = {SATP_PPN, {PG_IDX_W{1'b0}}};
    for (int i = 0; i < 16; i++) begin
      pte     = '0;
      pte.v   = (i % 4) != 2;
      pte.ppn = ppn_t'(i);
      pte.r   = (i % 4) == 0;
      pte.x   = (i % 4) == 0;
      pte.w   = (i % 4) == 3;
      if (i % 4 == 0) pte.ppn = ppn_t'(LEAF_BASE + i * 1024);
      if (i % 4 == 1) pte.ppn = ppn_t'(TABLE_BASE + i);
      page_table[root + paddr_t'(i * 4)] = pte;
      if (i % 4 == 1) begin
        l0_base = {ppn_t'(TABLE_BASE + i), {PG_IDX_W{1'b0}}};
        for (int j = 0; j < 16; j++) begin
          pte     = '0;
          pte.ppn = ppn_t'(LEAF_BASE + i * 16 + j);
          pte.v   = (j % 5) != 4;
          pte.r   = (j % 5) < 2;  // j%5 == 2 stays a pointer at the last level
          pte.w   = (j % 5) == 0 || (j % 5) == 3;
          pte.x   = (j % 5) == 1;
          page_table[l0_base + paddr_t'(j * 4)] = pte;
        end
      end
    end
  endtask

  task automatic reference_walk(input vpn_t vpn, output pte_t pte, output level_t level,
                                output logic fault, output int levels);
    paddr_t addr;
    addr   = {SATP_PPN, {PG_IDX_W{1'b0}}} + paddr_t'({vpn[VPN_W-1 -: VPN_FIELD_W], 2'b00});
    pte    = read_pte(addr);
    level  = level_t'(PG_LEVELS - 1);
    levels = 1;
    fault  = faulting_pte(pte);
    if (!fault && !leaf_pte(pte)) begin
      addr   = {pte.ppn, {PG_IDX_W{1'b0}}} + paddr_t'({vpn[VPN_FIELD_W-1:0], 2'b00});
      pte    = read_pte(addr);
      level  = '0;
      levels = 2;
      fault  = faulting_pte(pte);
    end
  endtask

  // memory model with random ready and 1 to 6 cycle latency
  always @(posedge clk) begin
    if (reset_n) begin
      mem_ready      <= ($urandom_range(0, 3) != 0);
      mem_resp_valid <= 1'b0;
      if (mem_busy) begin
        if (mem_delay <= 1) begin
          mem_resp_valid <= 1'b1;
          mem_resp_data  <= read_pte(mem_addr);
          mem_busy       <= 1'b0;
        end else begin
          mem_delay <= mem_delay - 1;
        end
      end else if (mem_req.valid && mem_ready) begin
        mem_busy      <= 1'b1;
        mem_addr      <= mem_req.addr;
        mem_delay     <= int'($urandom_range(1, 6));
        mem_req_count <= mem_req_count + 1;
      end
    end
  end

  task automatic flush_cache();
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(posedge clk);
  endtask

  task automatic send_req(input int port, input vpn_t vpn);
    req[port] <= '{valid: 1'b1, vpn: vpn};
  endtask

  task automatic wait_accept(input string name, input int port, output int base_count);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) abort_run($sformatf("%s: port %0d never granted", name, port));
    end while (!req_ready[port]);
    req[port] <= '0;
    base_count = mem_req_count;
  endtask

  task automatic wait_resp(input string name, input int port, input vpn_t vpn,
                           input logic cached, input int base_count);
    pte_t   exp_pte;
    level_t exp_level;
    logic   exp_fault;
    int     levels;
    int     cycles;
    reference_walk(vpn, exp_pte, exp_level, exp_fault, levels);
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (q != port) begin
          assert (!resp[q].valid) else
            abort_run($sformatf("%s: result showed up on port %0d", name, q));
        end
      end
      if (cycles > TIMEOUT_CYCLES) abort_run($sformatf("%s: no result on port %0d", name, port));
    end while (!resp[port].valid);
    check_value(name, "pte", 64'(exp_pte), 64'(resp[port].pte));
    check_value(name, "level", 64'(exp_level), 64'(resp[port].level));
    check_value(name, "fault", 64'(exp_fault), 64'(resp[port].fault));
    check_value(name, "memory requests", 64'(cached ? 0 : levels),
                64'(mem_req_count - base_count));
    if (cached) check_value(name, "latency", 64'(2 * levels), 64'(cycles)); // 2 per level
  endtask

  // a cold walk starts from an empty cache
  task automatic run_walk(input string name, input int port, input vpn_t vpn, input logic cached);
    int base_count;
    if (!cached) flush_cache();
    send_req(port, vpn);
    wait_accept(name, port, base_count);
    wait_resp(name, port, vpn, cached, base_count);
  endtask

  initial begin
    vpn_t vpn;
    int   port;
    int   base_count;
    void'($urandom(29995));
    build_page_table();
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);

    run_walk("two_level_miss", 0, {10'd1, 10'd5}, 1'b0);
    run_walk("two_level_hit", 0, {10'd1, 10'd5}, 1'b1);
    run_walk("superpage_miss", 1, {10'd4, 10'd7}, 1'b0);
    run_walk("superpage_hit", 1, {10'd4, 10'd7}, 1'b1);
    run_walk("invalid_l1", 0, {10'd2, 10'd0}, 1'b0);
    run_walk("w_without_r_l1", 1, {10'd3, 10'd0}, 1'b0);
    run_walk("invalid_l0", 0, {10'd5, 10'd4}, 1'b0);
    run_walk("w_without_r_l0", 0, {10'd5, 10'd3}, 1'b0);
    run_walk("pointer_at_last_level", 1, {10'd9, 10'd2}, 1'b0);

    // port 0 wins when both ports request at once
    flush_cache();
    send_req(0, {10'd1, 10'd0});
    send_req(1, {10'd4, 10'd1});
    wait_accept("dual_port0", 0, base_count);
    assert (!req_ready[1]) else abort_run("dual_port0: port 1 granted alongside port 0");
    wait_resp("dual_port0", 0, {10'd1, 10'd0}, 1'b0, base_count);
    wait_accept("dual_port1", 1, base_count);
    wait_resp("dual_port1", 1, {10'd4, 10'd1}, 1'b0, base_count);

    run_walk("after_flush", 0, {10'd1, 10'd5}, 1'b0);
    for (int k = 0; k < 4; k++) begin
      vpn  = {10'($urandom_range(0, 15)), 10'($urandom_range(0, 15))};
      port = int'($urandom_range(0, NUM_PORTS - 1));
      run_walk($sformatf("random_%0d", k), port, vpn, 1'b0);
    end

    run_done = 1'b1;
    $display("Regression passed");
    $finish;
  end

  final begin
    if (!run_done && !fail_shown) begin
      $display("Regression failed");
    end
  end

endmodule

/* verification/tb_ptw_asserts.sv */
`timescale 1ns/1ps

module tb_ptw_asserts
  import ptw_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  input logic                 i_clk,
  input logic                 i_reset_n,
  input logic [NUM_PORTS-1:0] i_req_ready,
  input walk_resp_t           i_resp [NUM_PORTS],
  input mem_req_t             i_mem_req,
  input logic                 i_mem_ready
);

  logic [NUM_PORTS-1:0] w_resp_valid;
  logic                 r_walk_open; // walk granted and result still due

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      w_resp_valid[p] = i_resp[p].valid;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_walk_open <= 1'b0;
    end else if (|i_req_ready) begin
      r_walk_open <= 1'b1;
    end else if (|w_resp_valid) begin
      r_walk_open <= 1'b0;
    end
  end

  ready_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(i_req_ready))
    else $error("o_req_ready has more than one bit set");

  resp_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(w_resp_valid))
    else $error("more than one o_resp valid in one cycle");

  resp_after_grant: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (|w_resp_valid) |-> r_walk_open)
    else $error("o_resp valid without an earlier grant");

  mem_req_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_mem_req.valid && !i_mem_ready) |=> $stable(i_mem_req))
    else $error("o_mem_req changed while waiting for i_mem_ready");

  // control outputs quiet on leaving reset
  reset_quiet: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> (i_req_ready == '0) && (w_resp_valid == '0) && !i_mem_req.valid)
    else $error("control outputs not low after reset");

endmodule

bind ptw_subsystem tb_ptw_asserts #(.NUM_PORTS(NUM_PORTS)) u_asserts (
  .i_clk       (i_clk),
  .i_reset_n   (i_reset_n),
  .i_req_ready (o_req_ready),
  .i_resp      (o_resp),
  .i_mem_req   (o_mem_req),
  .i_mem_ready (i_mem_ready)
);
